// File: flist.f
verilog/flash_pkg.sv
verilog/byte_ram.sv
verilog/flash_cmd_ctrl.sv
verilog/flash_read_engine.sv
verilog/flash_write_engine.sv
verilog/flash_update_top.sv
verification/flash_model.sv
verification/tb_flash_update.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the flash update helper testbench with Verilator and run it
# exits non-zero unless the run prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_flash_update -f flist.f -o tb_flash_update
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_flash_update)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verification/tb_flash_update.sv
/*
 * testbench for the flash update helper
 * drives host commands, checks strobes, page write, block read and busy flags
 */
`timescale 1ns/100ps

module tb_flash_update import flash_pkg::*; ();

	localparam int TIMEOUT  = 2000;  // cycles allowed per wait
	localparam int RD_BASE  = 'h150; // flash address of the read block
	localparam int RD_BYTES = 64;

	logic        clk_20 = 1'b0;
	logic        reset;
	cmd_t        cmd;
	flash_addr_t flash_addr;
	buf_addr_t   last_index, load_addr, rd_addr;
	byte_t       load_data, rd_data;
	logic        load_we;
	status_t     status;
	flash_ctrl_t flash_ctrl;
	flash_resp_t flash_resp;

	integer      seed = 13508;
	int          checks = 0;
	int          errors = 0;
	byte_t       wbuf_exp [PAGE_BYTES]; // bytes loaded into the write buffer
	byte_t       flash_exp [1024];      // copy of the model contents
	logic [9:0]  fidx;

	always #4 clk_20 = ~clk_20; // 8 ns period

	flash_update_top u_flash_update_top (.*);
	flash_model u_flash_model (.clk_20, .reset, .ctrl(flash_ctrl), .resp(flash_resp));

	// ======================================================================
	// reference and helpers
	// ======================================================================
	// flash keeps bytes lsb first
	function automatic byte_t bit_rev(input byte_t b);
		return {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("ERROR %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	function automatic logic status_bit(input int sel);
		case (sel)
			0:       return status.busy_fe;
			default: return status.read_active;
		endcase
	endfunction

	// polls at the falling edge away from the driving edge
	task automatic wait_status(input int sel, input logic level, input string what);
		int n;
		n = 0;
		@(negedge clk_20);
		while (status_bit(sel) != level && n < TIMEOUT) begin
			@(negedge clk_20);
			n++;
		end
		if (status_bit(sel) != level) begin
			errors++;
			$display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
			finish_run();
		end
	endtask

	task automatic issue_cmd(input cmd_t c);
		@(posedge clk_20);
		cmd <= c;
	endtask

	// flags drop one cycle after the command is registered
	task automatic clear_busy_flags();
		issue_cmd(CMD_BUSY_CLEAR);
		repeat (2) @(posedge clk_20);
		@(negedge clk_20);
		check_value("busy_clear", 0, int'({status.busy_re, status.busy_fe}));
		issue_cmd(CMD_IDLE);
	endtask

	// one strobe, one wren, one busy episode
	task automatic run_single_op(input cmd_t c, input string name);
		int n_wren, n_erase, n_en4b;
		n_wren  = u_flash_model.wren_count;
		n_erase = u_flash_model.erase_count;
		n_en4b  = u_flash_model.en4b_count;
		issue_cmd(c);
		wait_status(0, 1'b1, {name, " busy episode"});
		check_value({name, "_erase"}, (c == CMD_ERASE) ? 1 : 0,
			u_flash_model.erase_count - n_erase);
		check_value({name, "_en4b"}, (c == CMD_EXT_ADDR) ? 1 : 0,
			u_flash_model.en4b_count - n_en4b);
		check_value({name, "_wren"}, 1, u_flash_model.wren_count - n_wren);
		check_value({name, "_busy_edges"}, 3, int'({status.busy_re, status.busy_fe}));
		clear_busy_flags();
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		reset      <= 1'b1;
		cmd        <= CMD_IDLE;
		flash_addr <= flash_addr_t'(RD_BASE);
		last_index <= buf_addr_t'(RD_BYTES - 1);
		load_addr  <= '0;
		load_data  <= '0;
		load_we    <= 1'b0;
		rd_addr    <= '0;
		for (int i = 0; i < 1024; i++) begin
			flash_exp[i[9:0]]         = byte_t'($random(seed));
			u_flash_model.mem[i[9:0]] = flash_exp[i[9:0]];
		end
		repeat (4) @(posedge clk_20);
		reset <= 1'b0;
		repeat (2) @(negedge clk_20);
		check_value("reset_ctrl", 0, int'({flash_ctrl.read, flash_ctrl.rden, flash_ctrl.write,
			flash_ctrl.shift_bytes, flash_ctrl.sector_erase, flash_ctrl.wren,
			flash_ctrl.en4b_addr}));
		check_value("reset_flags", 0, int'({status.busy_re, status.busy_fe, status.read_active,
			status.busy, status.dv_seen, status.load_active}));
		check_value("status_cfg", ((RD_BYTES - 1) << 8) | ((RD_BASE >> 8) & 'hff),
			int'({status.last_index, status.addr_mid}));

		issue_cmd(CMD_LOAD); // decoded by the time the first byte lands
		for (int i = 0; i < PAGE_BYTES; i++) begin
			wbuf_exp[i[6:0]] = byte_t'($random(seed));
			@(posedge clk_20);
			load_addr <= i[7:0];
			load_data <= wbuf_exp[i[6:0]];
			load_we   <= 1'b1;
		end
		@(posedge clk_20);
		load_we <= 1'b0;
		for (int i = 0; i < PAGE_BYTES; i++) begin
			@(posedge clk_20);
			load_addr <= i[7:0];
			@(posedge clk_20);
			@(negedge clk_20); // port a read is registered
			check_value("load_readback", int'(wbuf_exp[i[6:0]]), int'(status.wbuf_byte));
		end

		issue_cmd(CMD_WRITE);
		wait_status(0, 1'b1, "page write busy episode");
		check_value("page_write_count", PAGE_BYTES, u_flash_model.cap_count);
		check_value("page_write_strobe", 1, u_flash_model.write_count);
		for (int i = 0; i < PAGE_BYTES; i++) begin
			check_value("page_write_byte", int'(bit_rev(wbuf_exp[i[6:0]])),
				int'(u_flash_model.cap[i[7:0]]));
		end
		clear_busy_flags();

		issue_cmd(CMD_READ);
		wait_status(1, 1'b1, "read to start");
		wait_status(1, 1'b0, "read to finish");
		issue_cmd(CMD_IDLE);
		check_value("read_strobe", 1, u_flash_model.read_count);
		for (int i = 0; i < RD_BYTES; i++) begin
			fidx = 10'(RD_BASE + i);
			@(posedge clk_20);
			rd_addr <= i[7:0];
			@(posedge clk_20);
			@(negedge clk_20);
			check_value("read_byte", int'(bit_rev(flash_exp[fidx])), int'(rd_data));
		end

		run_single_op(CMD_ERASE, "erase");
		run_single_op(CMD_EXT_ADDR, "ext_addr");
		finish_run();
	end

endmodule

// File: verification/flash_model.sv
/*
 * behavioral serial flash controller for the update helper testbench
 * stores 1024 bytes, counts strobes, answers modifying strobes with busy
 */
`timescale 1ns/100ps

module flash_model import flash_pkg::*; (
	input  logic        clk_20,
	input  logic        reset,
	input  flash_ctrl_t ctrl,
	output flash_resp_t resp
);

	localparam int BUSY_CYCLES = 12; // short stand-in for program and erase time
	localparam int DV_GAP      = 4;  // one read byte every 4 cycles

	byte_t       mem [1024];  // preloaded by the testbench
	byte_t       cap [256];   // datain seen with shift_bytes
	int          cap_count, read_count, write_count, erase_count, en4b_count, wren_count;
	int          busy_left;   // busy cycles still to go
	int          gap_cnt;     // spacing between data_valid pulses
	flash_addr_t rd_ptr;      // next stored byte to stream

	always @(posedge clk_20) begin
		if (reset) begin
			resp        <= '0;
			cap_count   <= 0;
			read_count  <= 0;
			write_count <= 0;
			erase_count <= 0;
			en4b_count  <= 0;
			wren_count  <= 0;
			busy_left   <= 0;
			gap_cnt     <= 0;
			rd_ptr      <= '0;
		end else begin
			resp.data_valid <= 1'b0;
			resp.busy       <= (busy_left != 0);
			if (ctrl.read) begin
				read_count <= read_count + 1;
				rd_ptr     <= ctrl.addr; // block starts here
				gap_cnt    <= 0;
			end else if (ctrl.rden) begin
				if (gap_cnt == DV_GAP - 1) begin
					gap_cnt         <= 0;
					resp.data_valid <= 1'b1;
					resp.dataout    <= mem[rd_ptr[9:0]]; // wraps at 1 KiB
					rd_ptr          <= rd_ptr + 1;
				end else begin
					gap_cnt <= gap_cnt + 1;
				end
			end
			// program, erase and 4 byte entry all look the same here
			if (ctrl.write || ctrl.sector_erase || ctrl.en4b_addr) begin
				busy_left <= BUSY_CYCLES;
			end else if (busy_left != 0) begin
				busy_left <= busy_left - 1;
			end
			if (ctrl.shift_bytes) begin
				cap[cap_count[7:0]] <= ctrl.datain;
				cap_count           <= cap_count + 1;
			end
			write_count <= write_count + int'(ctrl.write);
			erase_count <= erase_count + int'(ctrl.sector_erase);
			en4b_count  <= en4b_count + int'(ctrl.en4b_addr);
			wren_count  <= wren_count + int'(ctrl.wren);
		end
	end

endmodule

// File: verilog/flash_update_top.sv
/*
 * flash update helper top level
 * sits between host registers and an external serial flash controller in one clock domain
 */
`timescale 1ns/100ps

module flash_update_top import flash_pkg::*; (
	input  logic        clk_20,
	input  logic        reset,
	input  cmd_t        cmd,
	input  flash_addr_t flash_addr,
	input  buf_addr_t   last_index, // last read buffer address
	input  buf_addr_t   load_addr,  // write buffer load and readback address
	input  byte_t       load_data,
	input  logic        load_we,    // honoured only under CMD_LOAD
	input  buf_addr_t   rd_addr,    // read buffer address
	output byte_t       rd_data,
	output status_t     status,
	output flash_ctrl_t flash_ctrl,
	input  flash_resp_t flash_resp
);

	flash_addr_t addr_q;
	buf_addr_t   last_q;
	logic        cmd_read, cmd_write, cmd_load;
	logic        write_strobe, erase_strobe, en4b_strobe;
	logic        wren, busy, busy_re, busy_fe;
	logic        write_trigger, shift_bytes;
	logic        read_pulse, rden, read_active, dv_seen;
	buf_addr_t   rbuf_addr, wbuf_addr;
	byte_t       rbuf_data, wbuf_q, wbuf_byte, wr_datain;
	logic        rbuf_we;

	always_ff @(posedge clk_20) begin
		addr_q <= flash_addr;
		last_q <= last_index;
	end

	flash_cmd_ctrl u_cmd_ctrl (
		.clk_20, .reset, .cmd, .busy_raw(flash_resp.busy),
		.cmd_read, .cmd_write, .cmd_load, .write_trigger, .shift_bytes,
		.read_strobe(), .write_strobe, .erase_strobe, .en4b_strobe,
		.wren, .busy, .busy_re, .busy_fe
	);

	flash_read_engine u_read_engine (
		.clk_20, .reset, .cmd_read, .busy, .last_index(last_q), .resp(flash_resp),
		.read(read_pulse), .rden, .buf_addr(rbuf_addr), .buf_data(rbuf_data),
		.buf_we(rbuf_we), .read_active, .dv_seen
	);

	flash_write_engine u_write_engine (
		.clk_20, .reset, .cmd_write, .wbuf_q, .wbuf_addr,
		.shift_bytes, .write_trigger, .datain(wr_datain)
	);

	// engine fills port a and host reads port b
	byte_ram u_read_buf (
		.clk_20, .a_addr(rbuf_addr), .a_data(rbuf_data), .a_we(rbuf_we), .a_q(),
		.b_addr(rd_addr), .b_q(rd_data)
	);

	// host loads and reads back on port a while the sequencer reads port b
	byte_ram u_write_buf (
		.clk_20, .a_addr(load_addr), .a_data(load_data), .a_we(load_we && cmd_load),
		.a_q(wbuf_byte), .b_addr(wbuf_addr), .b_q(wbuf_q)
	);

	// ==================================================================
	// flash controller and status
	// ==================================================================
	assign flash_ctrl.read         = read_pulse;
	assign flash_ctrl.rden         = rden;
	assign flash_ctrl.write        = write_strobe;
	assign flash_ctrl.shift_bytes  = shift_bytes;
	assign flash_ctrl.sector_erase = erase_strobe;
	assign flash_ctrl.wren         = wren;
	assign flash_ctrl.en4b_addr    = en4b_strobe;
	assign flash_ctrl.addr         = addr_q;
	assign flash_ctrl.datain       = wr_datain;

	assign status = '{wbuf_byte: wbuf_byte, last_index: last_q, addr_mid: addr_q[15:8],
		load_active: cmd_load, read_active: read_active, busy_fe: busy_fe,
		busy_re: busy_re, illegal_erase: flash_resp.illegal_erase,
		illegal_write: flash_resp.illegal_write, dv_seen: dv_seen, busy: busy};

endmodule

// File: verilog/flash_write_engine.sv
/*
 * flash_write_engine: page write sequencer
 * shifts PAGE_BYTES buffered bytes, bit reversed, into the flash controller,
 * three cycles per byte, then holds WR_DONE to trigger the page program
 */
`timescale 1ns/100ps

module flash_write_engine import flash_pkg::*; (
	input  logic      clk_20,
	input  logic      reset,
	input  logic      cmd_write,     // low holds the sequencer idle
	input  byte_t     wbuf_q,        // write buffer port b data
	output buf_addr_t wbuf_addr,     // write buffer port b address
	output logic      shift_bytes,
	output logic      write_trigger,
	output byte_t     datain
);

	wr_state_t state, state_nxt;
	buf_addr_t wr_cnt;    // byte being shifted
	logic      last_byte;

	assign last_byte = (wr_cnt == buf_addr_t'(PAGE_BYTES - 1));

	// ==================================================================
	// next state
	// ==================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			WR_SETTLE:  state_nxt = WR_SHIFT;   // port b read completes
			WR_SHIFT:   state_nxt = WR_ADVANCE;
			WR_ADVANCE: begin
				if (last_byte) begin
					state_nxt = WR_DONE;
				end else begin
					state_nxt = WR_SETTLE;
				end
			end
			default:    state_nxt = WR_DONE;    // leave only when cmd_write drops
		endcase
	end

	always_ff @(posedge clk_20) begin
		if (reset || !cmd_write) begin
			state  <= WR_SETTLE;
			wr_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == WR_ADVANCE && !last_byte) begin
				wr_cnt <= wr_cnt + 8'd1;
			end
		end
	end

	// ==================================================================
	// outputs
	// ==================================================================
	assign wbuf_addr     = wr_cnt;
	assign shift_bytes   = (state == WR_SHIFT);
	assign write_trigger = (state == WR_DONE);  // edge detected into the write strobe
	assign datain        = {<<{wbuf_q}};        // flash takes bytes lsb first

endmodule

// File: verilog/flash_read_engine.sv
/*
 * flash_read_engine: reads a block of flash into the read buffer
 * bytes are bit reversed on capture; the controller spaces data_valid
 * at least 3 cycles apart and stops streaming once rden falls
 */
`timescale 1ns/100ps

module flash_read_engine import flash_pkg::*; (
	input  logic        clk_20,
	input  logic        reset,
	input  logic        cmd_read,    // low holds the engine in reset
	input  logic        busy,        // delayed busy
	input  buf_addr_t   last_index,  // last buffer address to fill
	input  flash_resp_t resp,
	output logic        read,        // one cycle start pulse
	output logic        rden,
	output buf_addr_t   buf_addr,
	output byte_t       buf_data,
	output logic        buf_we,
	output logic        read_active,
	output logic        dv_seen
);

	logic [8:0] addr_cnt; // spare msb so last_index 255 can be passed
	logic       dv_q;     // data_valid, byte now held in dout_rev
	logic       dv_q2;    // one more cycle, time to advance
	logic       in_range;
	logic       start_ok;
	byte_t      dout_rev;

	assign in_range = (addr_cnt <= {1'b0, last_index});
	assign start_ok = !busy || rden; // wait for idle flash only at the start

	// ==================================================================
	// control
	// ==================================================================
	always_ff @(posedge clk_20) begin
		if (reset || !cmd_read) begin
			addr_cnt <= '0;
			rden     <= 1'b0;
			read     <= 1'b0;
			dv_q     <= 1'b0;
			dv_q2    <= 1'b0;
		end else begin
			rden  <= start_ok && in_range;
			read  <= start_ok && in_range && !rden; // first cycle of rden only
			dv_q  <= resp.data_valid;
			dv_q2 <= dv_q;
			if (dv_q2 && in_range) begin
				addr_cnt <= addr_cnt + 9'd1; // two cycles after data_valid
			end
		end
	end

	// flash stores bytes lsb first
	always_ff @(posedge clk_20) begin
		if (resp.data_valid) begin
			dout_rev <= {<<{resp.dataout}};
		end
	end

	assign buf_addr    = addr_cnt[7:0];
	assign buf_data    = dout_rev;
	assign buf_we      = rden && dv_q;   // write the cycle after data_valid
	assign read_active = rden;
	assign dv_seen     = dv_q;

	// rden drops before a late byte could land past the block
	a_we_in_range: assert property (@(posedge clk_20) disable iff (reset)
		buf_we |-> (!addr_cnt[8] && buf_addr <= last_index));

endmodule

// File: verilog/flash_cmd_ctrl.sv
/*
 * flash_cmd_ctrl: registers and decodes the host command byte
 * makes the one cycle strobes for the flash controller, delays busy
 * and keeps the sticky busy edge flags
 */
`timescale 1ns/100ps

module flash_cmd_ctrl import flash_pkg::*; (
	input  logic clk_20,
	input  logic reset,
	input  cmd_t cmd,
	input  logic busy_raw,      // straight from the flash controller
	output logic cmd_read,      // level decodes of the registered command
	output logic cmd_write,
	output logic cmd_load,
	input  logic write_trigger, // write sequencer sitting in WR_DONE
	input  logic shift_bytes,
	output logic read_strobe,
	output logic write_strobe,
	output logic erase_strobe,
	output logic en4b_strobe,
	output logic wren,
	output logic busy,          // busy_raw BUSY_DELAY+1 cycles later
	output logic busy_re,       // sticky
	output logic busy_fe        // sticky, only after busy_re
);

	cmd_t                  cmd_q;
	logic                  busy_clear;
	logic [1:0]            rd_gen, wr_gen, er_gen, ext_gen, busy_gen; // edge shifters
	logic [BUSY_DELAY-1:0] busy_dly;

	// ==================================================================
	// command decode
	// ==================================================================
	assign cmd_read   = (cmd_q == CMD_READ);
	assign cmd_write  = (cmd_q == CMD_WRITE);
	assign cmd_load   = (cmd_q == CMD_LOAD);
	assign busy_clear = (cmd_q == CMD_BUSY_CLEAR);

	always_ff @(posedge clk_20) begin
		if (reset) begin
			cmd_q    <= CMD_IDLE;
			rd_gen   <= '0;
			wr_gen   <= '0;
			er_gen   <= '0;
			ext_gen  <= '0;
			busy_gen <= '0;
			busy_dly <= '0;
			busy     <= 1'b0;
		end else begin
			cmd_q    <= cmd;
			rd_gen   <= {rd_gen[0], cmd_read};
			wr_gen   <= {wr_gen[0], write_trigger}; // page program once the buffer is shifted in
			er_gen   <= {er_gen[0], cmd_q == CMD_ERASE};
			ext_gen  <= {ext_gen[0], cmd_q == CMD_EXT_ADDR};
			busy_dly <= {busy_dly[BUSY_DELAY-2:0], busy_raw};
			busy     <= busy_dly[BUSY_DELAY-1]; // controller wants a few idle cycles after busy
			busy_gen <= {busy_gen[0], busy};
		end
	end

	// rising edges only, two cycles after the command lands
	assign read_strobe  = (rd_gen == 2'b01);
	assign write_strobe = (wr_gen == 2'b01);
	assign erase_strobe = (er_gen == 2'b01);
	assign en4b_strobe  = (ext_gen == 2'b01);
	assign wren         = write_strobe | erase_strobe | en4b_strobe | shift_bytes;

	// ==================================================================
	// sticky busy edge flags, short busy pulses are easy to miss
	// ==================================================================
	always_ff @(posedge clk_20) begin
		if (reset || busy_clear) begin
			busy_re <= 1'b0;
			busy_fe <= 1'b0;
		end else begin
			if (busy_gen == 2'b01) begin
				busy_re <= 1'b1;
			end
			if (busy_re && busy_gen[1:0] inside {2'b10, 2'b00}) begin
				busy_fe <= 1'b1; // busy gone low after a seen rise
			end
		end
	end

	// read command and page write sequencer never overlap
	a_rd_wr_excl: assert property (@(posedge clk_20) disable iff (reset)
		!(read_strobe && write_strobe));

endmodule

// File: verilog/byte_ram.sv
/*
 * byte_ram: 256 x 8 buffer memory
 * port a is synchronous read/write (read-first), port b is registered read only
 */
`timescale 1ns/100ps

module byte_ram import flash_pkg::*; (
	input  logic      clk_20,
	input  buf_addr_t a_addr,
	input  byte_t     a_data,
	input  logic      a_we,
	output byte_t     a_q,
	input  buf_addr_t b_addr,
	output byte_t     b_q
);

	byte_t mem [2**$bits(buf_addr_t)]; // one entry per buffer address

	always_ff @(posedge clk_20) begin
		if (a_we) begin
			mem[a_addr] <= a_data;
		end
		a_q <= mem[a_addr]; // old data on a write to the same address
		b_q <= mem[b_addr]; // valid one cycle after b_addr
	end

endmodule

// File: verilog/flash_pkg.sv
/*
 * flash update helper shared definitions
 * widths, host command codes, write FSM states and flash controller structs
 */
package flash_pkg;

	typedef logic [7:0]  byte_t;       // one data byte
	typedef logic [7:0]  buf_addr_t;   // index into a 256 byte buffer
	typedef logic [31:0] flash_addr_t; // flash byte address

	localparam int PAGE_BYTES = 128; // bytes shifted per page write
	localparam int BUSY_DELAY = 4;   // busy delay stages before edge detect

	// host control byte codes
	typedef enum logic [7:0] {
		CMD_IDLE       = 8'h00,
		CMD_READ       = 8'h09,
		CMD_WRITE      = 8'h0A,
		CMD_EXT_ADDR   = 8'h0B,
		CMD_ERASE      = 8'h0C,
		CMD_LOAD       = 8'h0D,
		CMD_BUSY_CLEAR = 8'h0E
	} cmd_t;

	// page write sequencer, three states per byte then done
	typedef enum logic [1:0] {
		WR_SETTLE,  // buffer address settles, port b read in flight
		WR_SHIFT,   // byte on datain, shift_bytes high
		WR_ADVANCE, // step to next byte or finish
		WR_DONE     // page shifted in, hold write trigger
	} wr_state_t;

	// to the serial flash controller
	typedef struct packed {
		logic        read;         // start read, one cycle
		logic        rden;         // read enable, held for whole read
		logic        write;        // page program, one cycle
		logic        shift_bytes;  // load datain into page buffer
		logic        sector_erase; // one cycle
		logic        wren;         // write enable for any modifying op
		logic        en4b_addr;    // enter 4 byte addressing, one cycle
		flash_addr_t addr;
		byte_t       datain;       // already bit reversed
	} flash_ctrl_t;

	// from the serial flash controller
	typedef struct packed {
		byte_t dataout;       // flash bit order
		logic  busy;
		logic  data_valid;    // one cycle per read byte
		logic  illegal_write;
		logic  illegal_erase;
	} flash_resp_t;

	// host status word, msb first
	typedef struct packed {
		byte_t wbuf_byte;   // write buffer readback at load_addr
		byte_t last_index;
		byte_t addr_mid;    // flash_addr[15:8]
		logic  load_active;
		logic  read_active;
		logic  busy_fe;
		logic  busy_re;
		logic  illegal_erase;
		logic  illegal_write;
		logic  dv_seen;
		logic  busy;        // delayed busy
	} status_t;

endpackage
